/* src/tart_pkg.sv */
package tart_pkg;

   //---------------------------------------------------------------------
   // System bus widths
   //---------------------------------------------------------------------
   localparam int BBITS = 8;                 // Bus data width
   typedef logic [BBITS-1:0] bus_data_t;
   localparam int WBITS = 7;                 // Bus address width
   typedef logic [WBITS-1:0] bus_adr_t;
   localparam int CSUM_BITS = 24;            // Visibilities checksum

   // Device selects, taken from the top address bits
   localparam logic [3:0] CTRL_DEV = 4'hF;   // adr[6:3]
   localparam logic [2:0] ACQ_DEV  = 3'h0;   // adr[6:4]

   //---------------------------------------------------------------------
   // Reset/control unit, offsets on adr[1:0]
   //---------------------------------------------------------------------
   localparam logic [1:0] CTRL_STATUS   = 2'd0;
   localparam logic [1:0] CTRL_CSUM_LO  = 2'd1;
   localparam logic [1:0] CTRL_CSUM_MID = 2'd2;
   localparam logic [1:0] CTRL_CSUM_HI  = 2'd3;
   localparam int ST_RESET_BIT  = 7;         // Soft reset in progress
   localparam int ST_AQ_EN_BIT  = 2;
   localparam int ST_AQ_DBG_BIT = 1;
   localparam int ST_VX_EN_BIT  = 0;
   localparam int SRST_BIT      = 0;         // Write 1 to start soft reset

   //---------------------------------------------------------------------
   // Acquisition unit, offsets on adr[3:0]
   //---------------------------------------------------------------------
   localparam logic [3:0] AQ_CTRL   = 4'd0;
   localparam logic [3:0] AQ_DELAY  = 4'd1;
   localparam logic [3:0] VX_CTRL   = 4'd2;
   localparam logic [3:0] VX_BLOCK  = 4'd3;
   localparam logic [3:0] VX_STATUS = 4'd4;  // Read only
   localparam logic [3:0] VX_ACCESS = 4'd5;  // Read clears available
   localparam int AQ_EN_BIT     = 7;
   localparam int AQ_COUNT_BIT  = 2;
   localparam int AQ_SHIFT_BIT  = 1;
   localparam int AQ_DEBUG_BIT  = 0;
   localparam int AQ_DELAY_BITS = 3;
   localparam int VX_EN_BIT     = 7;
   localparam int VX_OVW_BIT    = 6;
   localparam int VS_DEBUG_BIT  = 7;
   localparam int VS_ENABLE_BIT = 6;
   localparam int VS_AVAIL_BIT  = 5;
   localparam int VS_OFLOW_BIT  = 4;
   localparam int VS_BANK_BITS  = 4;         // Bank field, bits 3..0

endpackage

/* src/tart_bus_decoder.sv */
`timescale 1ns/1ps

module tart_bus_decoder (
   input  logic                b_clk,
   input  logic                rst_i,

   // From the bus master
   input  logic                cyc_i,
   input  logic                stb_i,
   input  tart_pkg::bus_adr_t  adr_i,

   // Reset/control unit
   output logic                ctrl_stb_o,
   input  logic                ctrl_ack_i,
   input  tart_pkg::bus_data_t ctrl_dat_i,

   // Acquisition unit
   output logic                acq_stb_o,
   input  logic                acq_ack_i,
   input  tart_pkg::bus_data_t acq_dat_i,

   // Back to the master
   output logic                ack_o,
   output logic                err_o,
   output tart_pkg::bus_data_t dat_o
);

   logic ctrl_hit;
   logic acq_hit;
   logic miss_stb;
   logic ctrl_sel;
   logic acq_sel;
   logic miss_sel;

   //---------------------------------------------------------------------
   // Address decode
   //---------------------------------------------------------------------
   // Control unit lives at the top of the map, acquisition at the bottom
   assign ctrl_hit = adr_i[6:3] == tart_pkg::CTRL_DEV;
   assign acq_hit  = adr_i[6:4] == tart_pkg::ACQ_DEV;

   assign ctrl_stb_o = cyc_i && stb_i && ctrl_hit;
   assign acq_stb_o  = cyc_i && stb_i && acq_hit;
   assign miss_stb   = cyc_i && stb_i && !ctrl_hit && !acq_hit; // Unmapped

   //---------------------------------------------------------------------
   // Selection register
   //---------------------------------------------------------------------
   // Holds the target for the response cycle; a new strobe in the same
   // cycle simply overwrites it, since each response is one cycle long
   always_ff @(posedge b_clk) begin
      if (rst_i || !cyc_i) begin
         ctrl_sel <= 1'b0;
         acq_sel  <= 1'b0;
         miss_sel <= 1'b0;
      end else begin
         ctrl_sel <= ctrl_stb_o;
         acq_sel  <= acq_stb_o;
         miss_sel <= miss_stb;
      end
   end

   //---------------------------------------------------------------------
   // Response multiplexer
   //---------------------------------------------------------------------
   assign ack_o = ctrl_ack_i || acq_ack_i;  // Peers never ack together
   assign err_o = miss_sel;                 // Nobody home at that address

   always_comb begin
      if (ctrl_sel) begin
         dat_o = ctrl_dat_i;
      end else if (acq_sel) begin
         dat_o = acq_dat_i;
      end else begin
         dat_o = '0;                        // Idle or error cycle
      end
   end

endmodule

/* src/tart_control.sv */
`timescale 1ns/1ps

module tart_control #(
   parameter int RTIME = 4                  // Soft-reset length, cycles
) (
   input  logic                              b_clk,
   input  logic                              rst_i,

   // Bus slave port
   input  logic                              stb_i,
   input  logic                              we_i,
   input  logic [1:0]                        adr_i,
   input  tart_pkg::bus_data_t               dat_i,
   output logic                              ack_o,
   output tart_pkg::bus_data_t               dat_o,

   // System status in
   input  logic                              aq_enabled_i,
   input  logic                              aq_debug_i,
   input  logic                              vx_enabled_i,
   input  logic [tart_pkg::CSUM_BITS-1:0]    checksum_i,

   // Soft reset out
   output logic                              soft_rst_o
);

   localparam int CBITS = $clog2(RTIME + 1); // Room for RTIME itself

   logic [CBITS-1:0]    rcount;
   logic                rst_busy;
   logic                rst_req;
   tart_pkg::bus_data_t status;
   tart_pkg::bus_data_t rd_data;

   //---------------------------------------------------------------------
   // Status byte
   //---------------------------------------------------------------------
   always_comb begin
      status                          = '0;
      status[tart_pkg::ST_RESET_BIT]  = rst_busy;
      status[tart_pkg::ST_AQ_EN_BIT]  = aq_enabled_i;
      status[tart_pkg::ST_AQ_DBG_BIT] = aq_debug_i;
      status[tart_pkg::ST_VX_EN_BIT]  = vx_enabled_i;
   end

   // Read mux, checksum split into three bytes
   always_comb begin
      case (adr_i)
         tart_pkg::CTRL_STATUS:   rd_data = status;
         tart_pkg::CTRL_CSUM_LO:  rd_data = checksum_i[7:0];
         tart_pkg::CTRL_CSUM_MID: rd_data = checksum_i[15:8];
         default:                 rd_data = checksum_i[23:16]; // CTRL_CSUM_HI
      endcase
   end

   //---------------------------------------------------------------------
   // Bus response
   //---------------------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= stb_i;                    // Always one cycle later
      end
   end

   always_ff @(posedge b_clk) begin
      if (stb_i && !we_i) begin
         dat_o <= rd_data;
      end
   end

   //---------------------------------------------------------------------
   // Soft-reset timer
   //---------------------------------------------------------------------
   assign rst_busy = rcount != '0;
   assign rst_req  = stb_i && we_i && adr_i == tart_pkg::CTRL_STATUS &&
                     dat_i[tart_pkg::SRST_BIT];

   // Down-counter; requests while it runs are dropped
   always_ff @(posedge b_clk) begin
      if (rst_i) begin
         rcount <= '0;
      end else if (rst_req && !rst_busy) begin
         rcount <= CBITS'(RTIME);           // High from the ack cycle on
      end else if (rst_busy) begin
         rcount <= rcount - 1'b1;
      end
   end

   assign soft_rst_o = rst_busy;             // RTIME cycles wide

endmodule

/* src/tart_acquire.sv */
`timescale 1ns/1ps

module tart_acquire #(
   parameter int XBITS = 4                  // Bank counter width, 4 max
) (
   input  logic                                 b_clk,
   input  logic                                 rst_i,
   input  logic                                 soft_rst_i,

   // Bus slave port
   input  logic                                 stb_i,
   input  logic                                 we_i,
   input  logic [3:0]                           adr_i,
   input  tart_pkg::bus_data_t                  dat_i,
   output logic                                 ack_o,
   output tart_pkg::bus_data_t                  dat_o,

   // Correlator block events
   input  logic                                 newblock_i,
   input  logic                                 overflow_i,

   // Acquisition settings
   output logic                                 aq_enabled_o,
   output logic                                 aq_debug_o,
   output logic                                 aq_shift_o,
   output logic                                 aq_count_o,
   output logic [tart_pkg::AQ_DELAY_BITS-1:0]   aq_delay_o,

   // Visibilities settings
   output logic                                 vx_enabled_o,
   output logic                                 vx_overwrite_o,
   output tart_pkg::bus_data_t                  blocksize_o
);

   logic                clear;
   logic                wr_stb;
   logic                rd_stb;
   logic                accessed;
   logic                available;
   logic [XBITS-1:0]    bank;
   tart_pkg::bus_data_t vx_status;
   tart_pkg::bus_data_t rd_data;

   assign clear    = rst_i || soft_rst_i;
   assign wr_stb   = stb_i && we_i;
   assign rd_stb   = stb_i && !we_i;
   assign accessed = rd_stb && adr_i == tart_pkg::VX_ACCESS;

   //---------------------------------------------------------------------
   // Settings registers
   //---------------------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (clear) begin
         aq_enabled_o   <= 1'b0;
         aq_debug_o     <= 1'b0;
         aq_shift_o     <= 1'b0;
         aq_count_o     <= 1'b0;
         aq_delay_o     <= '0;
         vx_enabled_o   <= 1'b0;
         vx_overwrite_o <= 1'b0;
         blocksize_o    <= '0;
      end else if (wr_stb) begin
         case (adr_i)
            tart_pkg::AQ_CTRL: begin
               aq_enabled_o <= dat_i[tart_pkg::AQ_EN_BIT];
               aq_count_o   <= dat_i[tart_pkg::AQ_COUNT_BIT];
               aq_shift_o   <= dat_i[tart_pkg::AQ_SHIFT_BIT];
               aq_debug_o   <= dat_i[tart_pkg::AQ_DEBUG_BIT];
            end
            tart_pkg::AQ_DELAY: aq_delay_o <= dat_i[tart_pkg::AQ_DELAY_BITS-1:0];
            tart_pkg::VX_CTRL: begin
               vx_enabled_o   <= dat_i[tart_pkg::VX_EN_BIT];
               vx_overwrite_o <= dat_i[tart_pkg::VX_OVW_BIT];
            end
            tart_pkg::VX_BLOCK: blocksize_o <= dat_i;
            default: ;                      // Status offsets are read only
         endcase
      end
   end

   //---------------------------------------------------------------------
   // Bank counter and available flag
   //---------------------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (clear) begin
         bank      <= '0;
         available <= 1'b0;
      end else begin
         if (newblock_i) begin
            bank <= bank + 1'b1;            // Wraps at 2**XBITS
         end
         if (newblock_i) begin
            available <= 1'b1;              // New block beats the access
         end else if (accessed) begin
            available <= 1'b0;
         end
      end
   end

   always_comb begin
      vx_status                          = '0;
      vx_status[tart_pkg::VS_DEBUG_BIT]  = aq_debug_o;
      vx_status[tart_pkg::VS_ENABLE_BIT] = vx_enabled_o;
      vx_status[tart_pkg::VS_AVAIL_BIT]  = available;
      vx_status[tart_pkg::VS_OFLOW_BIT]  = overflow_i;
      vx_status[tart_pkg::VS_BANK_BITS-1:0] = tart_pkg::VS_BANK_BITS'(bank);
   end

   //---------------------------------------------------------------------
   // Read-back, only the defined bits
   //---------------------------------------------------------------------
   always_comb begin
      rd_data = '0;
      case (adr_i)
         tart_pkg::AQ_CTRL: begin
            rd_data[tart_pkg::AQ_EN_BIT]    = aq_enabled_o;
            rd_data[tart_pkg::AQ_COUNT_BIT] = aq_count_o;
            rd_data[tart_pkg::AQ_SHIFT_BIT] = aq_shift_o;
            rd_data[tart_pkg::AQ_DEBUG_BIT] = aq_debug_o;
         end
         tart_pkg::AQ_DELAY: rd_data[tart_pkg::AQ_DELAY_BITS-1:0] = aq_delay_o;
         tart_pkg::VX_CTRL: begin
            rd_data[tart_pkg::VX_EN_BIT]  = vx_enabled_o;
            rd_data[tart_pkg::VX_OVW_BIT] = vx_overwrite_o;
         end
         tart_pkg::VX_BLOCK:  rd_data = blocksize_o;
         tart_pkg::VX_STATUS: rd_data = vx_status;
         tart_pkg::VX_ACCESS: rd_data = vx_status; // Snapshot before clear
         default:             rd_data = '0;        // Unused offsets
      endcase
   end

   // Ack only follows rst_i, so a soft reset never drops a response
   always_ff @(posedge b_clk) begin
      if (rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= stb_i;
      end
   end

   always_ff @(posedge b_clk) begin
      if (rd_stb) begin
         dat_o <= rd_data;
      end
   end

endmodule

/* src/tart_bus_top.sv */
`timescale 1ns/1ps

module tart_bus_top #(
   parameter int RTIME = 4,                 // Soft-reset length
   parameter int XBITS = 4                  // Bank counter width
) (
   input  logic                                 b_clk,
   input  logic                                 rst_i,

   // System bus, from the external master
   input  logic                                 cyc_i,
   input  logic                                 stb_i,
   input  logic                                 we_i,
   input  tart_pkg::bus_adr_t                   adr_i,
   input  tart_pkg::bus_data_t                  dat_i,
   output logic                                 ack_o,
   output logic                                 err_o,
   output tart_pkg::bus_data_t                  dat_o,

   // Correlator side
   input  logic                                 newblock_i,
   input  logic                                 overflow_i,
   input  logic [tart_pkg::CSUM_BITS-1:0]       checksum_i,

   // Soft reset and settings
   output logic                                 reset_o,
   output logic                                 aq_enabled_o,
   output logic                                 aq_debug_o,
   output logic                                 aq_shift_o,
   output logic                                 aq_count_o,
   output logic [tart_pkg::AQ_DELAY_BITS-1:0]   aq_delay_o,
   output logic                                 vx_enabled_o,
   output logic                                 vx_overwrite_o,
   output tart_pkg::bus_data_t                  blocksize_o
);

   logic                ctrl_stb;
   logic                ctrl_ack;
   tart_pkg::bus_data_t ctrl_dat;
   logic                acq_stb;
   logic                acq_ack;
   tart_pkg::bus_data_t acq_dat;

   //---------------------------------------------------------------------
   // Address decoder and response mux
   //---------------------------------------------------------------------
   tart_bus_decoder u_decoder (
      .b_clk      (b_clk),
      .rst_i      (rst_i),
      .cyc_i      (cyc_i),
      .stb_i      (stb_i),
      .adr_i      (adr_i),
      .ctrl_stb_o (ctrl_stb),
      .ctrl_ack_i (ctrl_ack),
      .ctrl_dat_i (ctrl_dat),
      .acq_stb_o  (acq_stb),
      .acq_ack_i  (acq_ack),
      .acq_dat_i  (acq_dat),
      .ack_o      (ack_o),
      .err_o      (err_o),
      .dat_o      (dat_o)
   );

   //---------------------------------------------------------------------
   // Reset/control unit
   //---------------------------------------------------------------------
   tart_control #(
      .RTIME (RTIME)
   ) u_control (
      .b_clk        (b_clk),
      .rst_i        (rst_i),
      .stb_i        (ctrl_stb),
      .we_i         (we_i),
      .adr_i        (adr_i[1:0]),       // Four registers
      .dat_i        (dat_i),
      .ack_o        (ctrl_ack),
      .dat_o        (ctrl_dat),
      .aq_enabled_i (aq_enabled_o),
      .aq_debug_i   (aq_debug_o),
      .vx_enabled_i (vx_enabled_o),
      .checksum_i   (checksum_i),
      .soft_rst_o   (reset_o)
   );

   //---------------------------------------------------------------------
   // Acquisition control unit
   //---------------------------------------------------------------------
   tart_acquire #(
      .XBITS (XBITS)
   ) u_acquire (
      .b_clk          (b_clk),
      .rst_i          (rst_i),
      .soft_rst_i     (reset_o),        // Cleared by the soft reset too
      .stb_i          (acq_stb),
      .we_i           (we_i),
      .adr_i          (adr_i[3:0]),
      .dat_i          (dat_i),
      .ack_o          (acq_ack),
      .dat_o          (acq_dat),
      .newblock_i     (newblock_i),
      .overflow_i     (overflow_i),
      .aq_enabled_o   (aq_enabled_o),
      .aq_debug_o     (aq_debug_o),
      .aq_shift_o     (aq_shift_o),
      .aq_count_o     (aq_count_o),
      .aq_delay_o     (aq_delay_o),
      .vx_enabled_o   (vx_enabled_o),
      .vx_overwrite_o (vx_overwrite_o),
      .blocksize_o    (blocksize_o)
   );

endmodule

/* sim/tart_assertions.sv */
`timescale 1ns/1ps

module tart_assertions #(
   parameter int RTIME = 4
) (
   input logic b_clk,
   input logic rst_i,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_o,
   input logic err_o,
   input logic reset_o
);

   int reset_run;                           // Edges with reset_o high so far

   always_ff @(posedge b_clk) begin
      if (rst_i || !reset_o) begin
         reset_run <= 0;
      end else begin
         reset_run <= reset_run + 1;
      end
   end

   //---------------------------------------------------------------------
   // Bus handshake
   //---------------------------------------------------------------------
   a_ack_err_excl : assert property (@(posedge b_clk) disable iff (rst_i)
      !(ack_o && err_o))
      else $error("ack_o and err_o high together");

   // Exactly one response, on the next cycle
   a_one_resp : assert property (@(posedge b_clk) disable iff (rst_i)
      (cyc_i && stb_i) |=> (ack_o ^ err_o))
      else $error("request not answered on the next cycle");

   a_no_stray : assert property (@(posedge b_clk) disable iff (rst_i)
      (ack_o || err_o) |-> $past(cyc_i && stb_i))
      else $error("response without a request");

   a_reset_len : assert property (@(posedge b_clk) disable iff (rst_i)
      reset_run <= RTIME)
      else $error("soft reset longer than RTIME cycles");

endmodule

bind tart_bus_top tart_assertions #(
   .RTIME (RTIME)
) i_bus_assert (
   .b_clk   (b_clk),
   .rst_i   (rst_i),
   .cyc_i   (cyc_i),
   .stb_i   (stb_i),
   .ack_o   (ack_o),
   .err_o   (err_o),
   .reset_o (reset_o)
);

/* sim/tart_tb.sv */
`timescale 1ns/1ps

module tart_tb;

   localparam int SEED       = 18302;
   localparam int CLK_PERIOD = 20;
   localparam int RST_CYCLES = 10;
   localparam int RTIME      = 4;
   localparam int XBITS      = 4;
   localparam int N_RW       = 32;            // Settings write/read pairs
   localparam int N_CSUM     = 8;             // Status and checksum rounds
   localparam int N_BLK      = 6;             // Block-strobe bursts
   localparam int MAX_PULSES = 40;
   localparam int N_MISS     = 12;            // Unmapped requests
   localparam int TEST_CYCLES = RST_CYCLES + 60 + N_RW * 8 + N_CSUM * 12 +
                                N_BLK * (2 * MAX_PULSES + 20) + N_MISS * 4;
   localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

   // One expected bus response
   typedef struct packed {
      logic [31:0]         due;               // Cycle of the response
      logic                err;
      logic                chk;               // Compare read data
      tart_pkg::bus_data_t data;
   } resp_t;

   logic                          b_clk;
   logic                          rst_i;
   logic                          cyc_i;
   logic                          stb_i;
   logic                          we_i;
   tart_pkg::bus_adr_t            adr_i;
   tart_pkg::bus_data_t           dat_i;
   logic                          ack_o;
   logic                          err_o;
   tart_pkg::bus_data_t           dat_o;
   logic                          newblock_i;
   logic                          overflow_i;
   logic [tart_pkg::CSUM_BITS-1:0] checksum_i;
   logic                          reset_o;
   logic                          aq_enabled_o;
   logic                          aq_debug_o;
   logic                          aq_shift_o;
   logic                          aq_count_o;
   logic [2:0]                    aq_delay_o;
   logic                          vx_enabled_o;
   logic                          vx_overwrite_o;
   tart_pkg::bus_data_t           blocksize_o;

   // Register-map model
   tart_pkg::bus_data_t m_aq_ctrl;
   tart_pkg::bus_data_t m_aq_delay;
   tart_pkg::bus_data_t m_vx_ctrl;
   tart_pkg::bus_data_t m_block;
   logic                m_avail;
   logic                m_oflow;
   logic                m_busy;              // Soft reset in progress
   logic [3:0]          m_bank;              // Wraps at 16
   logic [23:0]         m_csum;

   resp_t exp_q[$];
   int    cycles = 0;
   int    errors = 0;
   int    resp_errors = 0;
   int    err_base = 0;
   int    tests = 0;

   tart_bus_top #(
      .RTIME (RTIME),
      .XBITS (XBITS)
   ) i_dut (.*);

   initial begin
      b_clk = 1'b0;
      forever #(CLK_PERIOD / 2) b_clk = ~b_clk;
   end

   //---------------------------------------------------------------------
   // Reference model
   //---------------------------------------------------------------------
   function automatic tart_pkg::bus_adr_t acq_adr(input logic [3:0] off);
      return {tart_pkg::ACQ_DEV, off};
   endfunction

   function automatic tart_pkg::bus_adr_t ctrl_adr(input logic [1:0] off);
      return {tart_pkg::CTRL_DEV, 1'b0, off};
   endfunction

   function automatic logic is_unmapped(input tart_pkg::bus_adr_t adr);
      return adr[6:3] != tart_pkg::CTRL_DEV && adr[6:4] != tart_pkg::ACQ_DEV;
   endfunction

   // Expected read data for one address
   function automatic tart_pkg::bus_data_t ref_read(input tart_pkg::bus_adr_t adr);
      if (adr[6:3] == tart_pkg::CTRL_DEV) begin
         case (adr[1:0])
            tart_pkg::CTRL_STATUS:   return {m_busy, 4'b0, m_aq_ctrl[7], m_aq_ctrl[0],
                                             m_vx_ctrl[7]};
            tart_pkg::CTRL_CSUM_LO:  return m_csum[7:0];
            tart_pkg::CTRL_CSUM_MID: return m_csum[15:8];
            default:                 return m_csum[23:16];
         endcase
      end else if (adr[6:4] == tart_pkg::ACQ_DEV) begin
         case (adr[3:0])
            tart_pkg::AQ_CTRL:   return m_aq_ctrl;
            tart_pkg::AQ_DELAY:  return m_aq_delay;
            tart_pkg::VX_CTRL:   return m_vx_ctrl;
            tart_pkg::VX_BLOCK:  return m_block;
            tart_pkg::VX_STATUS,
            tart_pkg::VX_ACCESS: return {m_aq_ctrl[0], m_vx_ctrl[7], m_avail, m_oflow, m_bank};
            default:             return 8'h00;
         endcase
      end
      return 8'h00;
   endfunction

   // Settings keep only their defined bits
   function automatic void model_write(input logic [3:0] off, input tart_pkg::bus_data_t d);
      case (off)
         tart_pkg::AQ_CTRL:  m_aq_ctrl  = d & 8'h87;  // Enable, count, shift, debug
         tart_pkg::AQ_DELAY: m_aq_delay = d & 8'h07;
         tart_pkg::VX_CTRL:  m_vx_ctrl  = d & 8'hC0;  // Enable, overwrite
         tart_pkg::VX_BLOCK: m_block    = d;
         default: ;
      endcase
   endfunction

   function automatic int check_eq(input string name, input logic [7:0] got,
                                   input logic [7:0] exp);
      assert (got === exp) else begin
         $display("Error: %s = %h, expected %h", name, got, exp);
         return 1;
      end
      return 0;
   endfunction

   //---------------------------------------------------------------------
   // Bus master
   //---------------------------------------------------------------------
   // Called 2 ns after an edge and returns 2 ns after the strobe edge
   task automatic bus_cycle(input logic we, input tart_pkg::bus_adr_t adr,
                            input tart_pkg::bus_data_t d);
      resp_t r;
      r.due  = cycles + 1;
      r.err  = is_unmapped(adr);
      r.chk  = !we && !r.err;
      r.data = we ? 8'h00 : ref_read(adr);
      if (we && adr[6:4] == tart_pkg::ACQ_DEV) model_write(adr[3:0], d);
      if (!we && adr == acq_adr(tart_pkg::VX_ACCESS)) m_avail = 1'b0;
      exp_q.push_back(r);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = we;
      adr_i = adr;
      dat_i = d;
      @(posedge b_clk);
      #2;
      stb_i = 1'b0;                           // Next call may re-raise it
      we_i  = 1'b0;
   endtask

   task automatic idle(input int n);
      cyc_i = 1'b0;
      repeat (n) begin
         @(posedge b_clk);
         #2;
      end
   endtask

   task automatic check_outputs();
      errors += check_eq("reset_o", 8'(reset_o), 8'h00);
      errors += check_eq("aq_enabled_o", 8'(aq_enabled_o), 8'(m_aq_ctrl[7]));
      errors += check_eq("aq_count_o", 8'(aq_count_o), 8'(m_aq_ctrl[2]));
      errors += check_eq("aq_shift_o", 8'(aq_shift_o), 8'(m_aq_ctrl[1]));
      errors += check_eq("aq_debug_o", 8'(aq_debug_o), 8'(m_aq_ctrl[0]));
      errors += check_eq("aq_delay_o", 8'(aq_delay_o), m_aq_delay);
      errors += check_eq("vx_enabled_o", 8'(vx_enabled_o), 8'(m_vx_ctrl[7]));
      errors += check_eq("vx_overwrite_o", 8'(vx_overwrite_o), 8'(m_vx_ctrl[6]));
      errors += check_eq("blocksize_o", blocksize_o, m_block);
   endtask

   // Wait out the pending responses, then report the test
   task automatic finish_test(input string name);
      int e;
      while (exp_q.size() != 0) begin
         @(posedge b_clk);
         #2;
      end
      check_outputs();
      tests++;
      e = errors + resp_errors - err_base;
      err_base = errors + resp_errors;
      $display("Test %0d, %s: done with %0d errors", tests, name, e);
   endtask

   //---------------------------------------------------------------------
   // Response comparison and run limit
   //---------------------------------------------------------------------
   always @(negedge b_clk) begin : compare_resp
      resp_t r;
      if (exp_q.size() != 0 && exp_q[0].due == cycles) begin
         r = exp_q.pop_front();
         resp_errors += check_eq("ack_o", 8'(ack_o), 8'(!r.err));
         resp_errors += check_eq("err_o", 8'(err_o), 8'(r.err));
         if (r.chk) resp_errors += check_eq("dat_o", dat_o, r.data);
      end else if (cycles != 0) begin        // Outputs unknown before the first edge
         assert (!ack_o && !err_o) else begin
            $display("Bus response seen with no request pending");
            resp_errors++;
         end
      end
   end

   always @(posedge b_clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, tests did not complete", cycles);
         $display("Finished with errors");
         $finish;
      end
   end

   //---------------------------------------------------------------------
   // Tests
   //---------------------------------------------------------------------
   initial begin : main
      logic [31:0] rnd;
      logic [3:0]  off;
      int          n;
      int          pulses;

      void'($urandom(SEED));
      rst_i      = 1'b1;
      cyc_i      = 1'b0;
      stb_i      = 1'b0;
      we_i       = 1'b0;
      adr_i      = '0;
      dat_i      = '0;
      newblock_i = 1'b0;
      overflow_i = 1'b0;
      checksum_i = '0;
      m_aq_ctrl  = '0;
      m_aq_delay = '0;
      m_vx_ctrl  = '0;
      m_block    = '0;
      m_avail    = 1'b0;
      m_oflow    = 1'b0;
      m_busy     = 1'b0;
      m_bank     = '0;
      m_csum     = '0;
      repeat (RST_CYCLES) @(posedge b_clk);
      #2;
      rst_i = 1'b0;

      for (int i = 0; i < 16; i++) bus_cycle(1'b0, acq_adr(4'(i)), 8'h00);
      finish_test("reset values");

      for (int i = 0; i < N_RW; i++) begin
         rnd = $urandom;
         off = 4'(rnd[9:8]);                  // AQ_CTRL up to VX_BLOCK
         bus_cycle(1'b1, acq_adr(off), rnd[7:0]);
         bus_cycle(1'b0, acq_adr(off), 8'h00); // Pipelined read-back
         idle($urandom_range(0, 2));
      end
      for (int i = 0; i < 4; i++) bus_cycle(1'b0, acq_adr(4'(i)), 8'h00);
      finish_test("settings read-back");

      for (int i = 0; i < N_CSUM; i++) begin
         rnd = $urandom;
         bus_cycle(1'b1, acq_adr(tart_pkg::AQ_CTRL), rnd[7:0]);
         bus_cycle(1'b1, acq_adr(tart_pkg::VX_CTRL), rnd[15:8]);
         rnd        = $urandom;
         m_csum     = rnd[23:0];
         checksum_i = m_csum;
         for (int j = 0; j < 4; j++) bus_cycle(1'b0, ctrl_adr(2'(j)), 8'h00);
         idle(1);
      end
      finish_test("status and checksum");

      rnd = $urandom;
      bus_cycle(1'b1, acq_adr(tart_pkg::AQ_CTRL), 8'hFF);
      bus_cycle(1'b1, acq_adr(tart_pkg::AQ_DELAY), 8'hFF);
      bus_cycle(1'b1, acq_adr(tart_pkg::VX_CTRL), 8'hFF);
      bus_cycle(1'b1, acq_adr(tart_pkg::VX_BLOCK), rnd[7:0] | 8'h01);
      newblock_i = 1'b1;
      @(posedge b_clk);
      #2;
      newblock_i = 1'b0;
      m_bank     = m_bank + 1'b1;
      m_avail    = 1'b1;
      bus_cycle(1'b1, ctrl_adr(tart_pkg::CTRL_STATUS), 8'h01);
      m_busy = 1'b1;                          // Busy bit seen in the first reset cycle
      bus_cycle(1'b0, ctrl_adr(tart_pkg::CTRL_STATUS), 8'h00);
      m_busy = 1'b0;
      n = 1;                                  // That cycle went to the status read
      while (reset_o === 1'b1 && n < 4 * RTIME) begin
         n++;
         @(posedge b_clk);
         #2;
      end
      errors += check_eq("reset_o cycles", 8'(n), 8'(RTIME));
      m_aq_ctrl  = '0;                        // Soft reset clears the unit
      m_aq_delay = '0;
      m_vx_ctrl  = '0;
      m_block    = '0;
      m_avail    = 1'b0;
      m_bank     = '0;
      for (int i = 0; i < 6; i++) bus_cycle(1'b0, acq_adr(4'(i)), 8'h00);
      finish_test("soft reset");

      for (int i = 0; i < N_BLK; i++) begin
         rnd = $urandom;
         bus_cycle(1'b1, acq_adr(tart_pkg::AQ_CTRL), rnd[7:0]);
         bus_cycle(1'b1, acq_adr(tart_pkg::VX_CTRL), rnd[15:8]);
         idle(0);
         pulses = $urandom_range(1, MAX_PULSES);
         repeat (pulses) begin
            newblock_i = 1'b1;
            @(posedge b_clk);
            #2;
            newblock_i = 1'b0;
            if ($urandom_range(0, 1) == 1) begin
               @(posedge b_clk);
               #2;
            end
         end
         m_bank     = m_bank + 4'(pulses);
         m_avail    = 1'b1;
         overflow_i = rnd[16];
         m_oflow    = rnd[16];
         bus_cycle(1'b0, acq_adr(tart_pkg::VX_STATUS), 8'h00);
         bus_cycle(1'b0, acq_adr(tart_pkg::VX_ACCESS), 8'h00);
         bus_cycle(1'b0, acq_adr(tart_pkg::VX_STATUS), 8'h00); // Available gone
         idle(1);
      end
      finish_test("block strobes");

      for (int i = 0; i < N_MISS; i++) begin
         rnd = $urandom;
         n   = 16 + $urandom_range(0, 103);  // Gap between the two units
         bus_cycle(rnd[8], 7'(n), rnd[7:0]);
         bus_cycle(1'b0, acq_adr(tart_pkg::AQ_DELAY), 8'h00);
         idle(int'(rnd[9]));
      end
      finish_test("unmapped addresses");

      $display("%0d tests run, %0d errors", tests, errors + resp_errors);
      if (errors + resp_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* files.f */
src/tart_pkg.sv
src/tart_bus_decoder.sv
src/tart_control.sv
src/tart_acquire.sv
src/tart_bus_top.sv
sim/tart_assertions.sv
sim/tart_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tart_tb
RTL_TOP   ?= tart_bus_top
FLIST     ?= files.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= Finished with no errors

RTL_SRCS := $(filter src/%,$(shell cat $(FLIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	@out="$$(./$(BUILD)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD)
